// ==== nes_glue_pkg.sv ====
`default_nettype none

package nes_glue_pkg;

  // one controller, msb first as the NES shifts it out last
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } pad_buttons_t;

  // serial chain per port holds two players and a signature
  localparam int JOY_CHAIN_BITS = 24;

  // multitap signature bytes
  localparam logic [7:0] MULTITAP_SIG_P3 = 8'h08;
  localparam logic [7:0] MULTITAP_SIG_P4 = 8'h04;

  // hold-off after a download ends
  localparam logic [7:0] DL_RESET_CYCLES = 8'd255;

  // sdram and ppu address spaces
  typedef logic [24:0] mem_addr_t;
  typedef logic [21:0] ppu_addr_t;
  typedef logic [17:0] save_addr_t;

  // battery save lives in its own sdram region
  localparam logic [6:0] SAVE_REGION_PREFIX = 7'b0001111;

  // header flags from the loader
  typedef logic [63:0] mapper_flags_t;

  // battery bit inside the flag word
  localparam int HAS_SAVE_BIT = 25;

endpackage

`default_nettype wire

// ==== load_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface load_if (
  input logic clk_ppu_21_47,
  input logic loader_done
);

  // raw download level from the host
  logic downloading;
  // download running or loader still parsing
  logic load_active;
  // single cycle at the start of a download
  logic download_start;

  modport sequencer (
    output downloading,
    output load_active,
    output download_start
  );

  modport consumer (
    input clk_ppu_21_47,
    input downloading,
    input load_active,
    input download_start,
    input loader_done
  );

endinterface

`default_nettype wire

// ==== reset_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module reset_sequencer import nes_glue_pkg::*; (
  input  logic clk_ppu_21_47,
  input  logic reset_nes,
  input  logic ioctl_download,
  input  logic loader_busy,
  input  logic loader_fail,
  input  logic hold_reset,
  output logic core_reset,
  output logic loader_reset,
  load_if.sequencer load
);

  // machine stays in reset until a first download has been seen
  logic       init_done;
  logic       prev_download;
  logic [7:0] dl_cnt;

  assign load.downloading    = ioctl_download;
  assign load.load_active    = ioctl_download | loader_busy;
  assign load.download_start = ioctl_download & ~prev_download;

  // post-download counter, frozen while the loader is busy
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      dl_cnt <= '0;
    end else if (ioctl_download) begin
      dl_cnt <= DL_RESET_CYCLES;
    end else if (!loader_busy && dl_cnt != '0) begin
      dl_cnt <= dl_cnt - 8'd1;
    end
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      init_done     <= 1'b0;
      prev_download <= 1'b0;
      loader_reset  <= 1'b1;
    end else begin
      if (ioctl_download) begin
        init_done <= 1'b1;
      end
      prev_download <= ioctl_download;
      // loader idles in reset once the counter has run out,
      // and gets a fresh reset at the start of every download
      loader_reset  <= (dl_cnt == '0) | load.download_start;
    end
  end

  assign core_reset = ~init_done | (dl_cnt != '0) | loader_fail | hold_reset;

  // the loader must see reset right after a download begins
  a_loader_reset_on_start: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    load.download_start |=> loader_reset
  );

  // no core activity while the hold-off is counting
  a_core_reset_while_counting: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    (dl_cnt != '0) |-> core_reset
  );

endmodule

`default_nettype wire

// ==== cart_config.sv ====
`timescale 1ns/1ns
`default_nettype none

module cart_config import nes_glue_pkg::*; (
  input  logic          clk_ppu_21_47,
  input  logic          reset_nes,
  input  mapper_flags_t loader_flags,
  load_if.consumer      load,
  output mapper_flags_t core_mapper_flags,
  output logic          has_save
);

  // last flag word the loader reported as good
  mapper_flags_t flags_q;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      flags_q <= '0;
    end else if (load.loader_done) begin
      flags_q <= loader_flags;
    end
  end

  // core sees no mapper while a new image is coming in
  assign core_mapper_flags = load.downloading ? '0 : flags_q;

  assign has_save = flags_q[HAS_SAVE_BIT];

endmodule

`default_nettype wire

// ==== joypad_ports.sv ====
`timescale 1ns/1ns
`default_nettype none

module joypad_ports import nes_glue_pkg::*; (
  input  logic         clk_ppu_21_47,
  input  logic         core_reset,
  input  logic         multitap_enabled,
  input  logic         joypad_latch,
  input  logic [1:0]   joypad_clock,
  input  pad_buttons_t p1_buttons,
  input  pad_buttons_t p2_buttons,
  input  pad_buttons_t p3_buttons,
  input  pad_buttons_t p4_buttons,
  output logic [4:0]   joypad1_data,
  output logic [4:0]   joypad2_data
);

  localparam int UPPER_BITS = JOY_CHAIN_BITS - 8;

  // parallel load words, one per port
  logic [JOY_CHAIN_BITS-1:0] load_val [2];
  // current serial bit of each chain
  logic [1:0]                serial_bit;

  // without multitap the upper part reads as all ones,
  // like an open bus behind a single pad
  assign load_val[0] = multitap_enabled ? {MULTITAP_SIG_P3, p3_buttons, p1_buttons}
                                        : {{UPPER_BITS{1'b1}}, p1_buttons};
  assign load_val[1] = multitap_enabled ? {MULTITAP_SIG_P4, p4_buttons, p2_buttons}
                                        : {{UPPER_BITS{1'b1}}, p2_buttons};

  for (genvar g = 0; g < 2; g++) begin : g_port
    logic [JOY_CHAIN_BITS-1:0] bits;
    logic                      clk_q;
    logic                      shift;

    // shift strobe is the falling edge of the port clock
    assign shift = clk_q & ~joypad_clock[g];

    always_ff @(posedge clk_ppu_21_47) begin
      if (core_reset) begin
        bits  <= '0;
        clk_q <= 1'b0;
      end else begin
        // shift beats latch on a shared edge
        if (shift) begin
          bits <= {1'b0, bits[JOY_CHAIN_BITS-1:1]};
        end else if (joypad_latch) begin
          bits <= load_val[g];
        end
        clk_q <= joypad_clock[g];
      end
    end

    assign serial_bit[g] = bits[0];

    // a chain held in reset stays empty, so nothing shifts out
    a_no_shift_in_reset: assert property (
      @(posedge clk_ppu_21_47)
      core_reset |=> (bits == '0 && !clk_q)
    );
  end

  // only bit 0 carries pad data now that the other peripherals are gone
  assign joypad1_data = {4'b0000, serial_bit[0]};
  assign joypad2_data = {4'b0000, serial_bit[1]};

endmodule

`default_nettype wire

// ==== sdram_port_router.sv ====
`timescale 1ns/1ns
`default_nettype none

module sdram_port_router import nes_glue_pkg::*; (
  load_if.consumer   load,
  input  mem_addr_t  loader_addr,
  input  logic [7:0] loader_write_data,
  input  logic       loader_write,
  input  ppu_addr_t  ppu_addr,
  input  logic [7:0] ppu_dout,
  input  logic       ppu_write,
  input  logic       ppu_read,
  input  save_addr_t sd_buff_addr,
  input  logic [7:0] sd_buff_dout,
  input  logic       sd_buff_wr,
  input  logic       sd_buff_rd,
  input  logic       save_busy,
  input  logic [7:0] save_dout,
  input  logic [7:0] eeprom_dout,
  input  logic       bram_en,
  output mem_addr_t  ch0_addr,
  output logic [7:0] ch0_din,
  output logic       ch0_wr,
  output logic       ch0_rd,
  output mem_addr_t  ch2_addr,
  output logic [7:0] ch2_din,
  output logic       ch2_wr,
  output logic       ch2_rd,
  output logic [7:0] sd_buff_din
);

  localparam int PPU_PAD_BITS = $bits(mem_addr_t) - $bits(ppu_addr_t);

  // channel 0 belongs to the loader for the whole load
  assign ch0_addr = load.load_active ? loader_addr
                                     : {{PPU_PAD_BITS{1'b0}}, ppu_addr};
  assign ch0_din  = load.load_active ? loader_write_data : ppu_dout;
  assign ch0_wr   = loader_write | ppu_write;
  assign ch0_rd   = ~load.load_active & ppu_read;

  // channel 2 is the battery save buffer
  assign ch2_addr = {SAVE_REGION_PREFIX, sd_buff_addr};
  assign ch2_din  = sd_buff_dout;

  // sdram only sees an edge on a non-busy cycle,
  // so requests during busy are simply dropped
  assign ch2_wr = sd_buff_wr & ~save_busy;
  assign ch2_rd = sd_buff_rd & ~save_busy;

  // mapper eeprom takes over the save read-back
  assign sd_buff_din = bram_en ? eeprom_dout : save_dout;

  // ppu reads must not collide with loader writes
  a_no_read_while_loading: assert property (
    @(posedge load.clk_ppu_21_47)
    load.load_active |-> !ch0_rd
  );

endmodule

`default_nettype wire

// ==== nes_glue_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module nes_glue_top import nes_glue_pkg::*; (
  input  logic          clk_ppu_21_47,
  input  logic          reset_nes,
  // loader status
  input  logic          ioctl_download,
  input  logic          loader_busy,
  input  logic          loader_done,
  input  logic          loader_fail,
  input  logic          hold_reset,
  input  mapper_flags_t loader_flags,
  output logic          core_reset,
  output logic          loader_reset,
  output mapper_flags_t core_mapper_flags,
  output logic          has_save,
  // controllers
  input  logic          multitap_enabled,
  input  logic          joypad_latch,
  input  logic [1:0]    joypad_clock,
  input  pad_buttons_t  p1_buttons,
  input  pad_buttons_t  p2_buttons,
  input  pad_buttons_t  p3_buttons,
  input  pad_buttons_t  p4_buttons,
  output logic [4:0]    joypad1_data,
  output logic [4:0]    joypad2_data,
  // sdram traffic sources
  input  mem_addr_t     loader_addr,
  input  logic [7:0]    loader_write_data,
  input  logic          loader_write,
  input  ppu_addr_t     ppu_addr,
  input  logic [7:0]    ppu_dout,
  input  logic          ppu_write,
  input  logic          ppu_read,
  // save buffer
  input  save_addr_t    sd_buff_addr,
  input  logic [7:0]    sd_buff_dout,
  input  logic          sd_buff_wr,
  input  logic          sd_buff_rd,
  input  logic          save_busy,
  input  logic [7:0]    save_dout,
  input  logic [7:0]    eeprom_dout,
  input  logic          bram_en,
  output logic [7:0]    sd_buff_din,
  // sdram channels
  output mem_addr_t     ch0_addr,
  output logic [7:0]    ch0_din,
  output logic          ch0_wr,
  output logic          ch0_rd,
  output mem_addr_t     ch2_addr,
  output logic [7:0]    ch2_din,
  output logic          ch2_wr,
  output logic          ch2_rd
);

  load_if load (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .loader_done   (loader_done)
  );

  reset_sequencer u_reset_sequencer (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .ioctl_download(ioctl_download),
    .loader_busy   (loader_busy),
    .loader_fail   (loader_fail),
    .hold_reset    (hold_reset),
    .core_reset    (core_reset),
    .loader_reset  (loader_reset),
    .load          (load.sequencer)
  );

  cart_config u_cart_config (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .loader_flags     (loader_flags),
    .load             (load.consumer),
    .core_mapper_flags(core_mapper_flags),
    .has_save         (has_save)
  );

  joypad_ports u_joypad_ports (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .core_reset      (core_reset),
    .multitap_enabled(multitap_enabled),
    .joypad_latch    (joypad_latch),
    .joypad_clock    (joypad_clock),
    .p1_buttons      (p1_buttons),
    .p2_buttons      (p2_buttons),
    .p3_buttons      (p3_buttons),
    .p4_buttons      (p4_buttons),
    .joypad1_data    (joypad1_data),
    .joypad2_data    (joypad2_data)
  );

  sdram_port_router u_sdram_port_router (
    .load             (load.consumer),
    .loader_addr      (loader_addr),
    .loader_write_data(loader_write_data),
    .loader_write     (loader_write),
    .ppu_addr         (ppu_addr),
    .ppu_dout         (ppu_dout),
    .ppu_write        (ppu_write),
    .ppu_read         (ppu_read),
    .sd_buff_addr     (sd_buff_addr),
    .sd_buff_dout     (sd_buff_dout),
    .sd_buff_wr       (sd_buff_wr),
    .sd_buff_rd       (sd_buff_rd),
    .save_busy        (save_busy),
    .save_dout        (save_dout),
    .eeprom_dout      (eeprom_dout),
    .bram_en          (bram_en),
    .ch0_addr         (ch0_addr),
    .ch0_din          (ch0_din),
    .ch0_wr           (ch0_wr),
    .ch0_rd           (ch0_rd),
    .ch2_addr         (ch2_addr),
    .ch2_din          (ch2_din),
    .ch2_wr           (ch2_wr),
    .ch2_rd           (ch2_rd),
    .sd_buff_din      (sd_buff_din)
  );

endmodule

`default_nettype wire

// ==== tb_nes_glue.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_nes_glue import nes_glue_pkg::*; ();

  logic          clk_ppu_21_47 = 1'b0;
  logic          reset_nes;
  logic          ioctl_download, loader_busy, loader_done, loader_fail, hold_reset;
  mapper_flags_t loader_flags;
  logic          core_reset, loader_reset, has_save;
  mapper_flags_t core_mapper_flags;
  logic          multitap_enabled, joypad_latch;
  logic [1:0]    joypad_clock;
  pad_buttons_t  p1_buttons, p2_buttons, p3_buttons, p4_buttons;
  logic [4:0]    joypad1_data, joypad2_data;
  mem_addr_t     loader_addr, ch0_addr, ch2_addr;
  ppu_addr_t     ppu_addr;
  save_addr_t    sd_buff_addr;
  logic [7:0]    loader_write_data, ppu_dout, sd_buff_dout, save_dout, eeprom_dout;
  logic [7:0]    sd_buff_din, ch0_din, ch2_din;
  logic          loader_write, ppu_write, ppu_read, sd_buff_wr, sd_buff_rd;
  logic          save_busy, bram_en, ch0_wr, ch0_rd, ch2_wr, ch2_rd;

  integer seed;
  int     errors, timeouts, checks;
  logic   model_ready, timed_out;

  // reference model state
  logic [7:0]    m_cnt;
  logic          m_init, m_prev, m_lreset;
  mapper_flags_t m_flags;
  logic [23:0]   m_chain1, m_chain2;
  logic [1:0]    m_clkq;

  nes_glue_top dut (.*);

  always #5 clk_ppu_21_47 = ~clk_ppu_21_47;

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  // word a port loads on latch with bit 0 leaving first
  function automatic logic [23:0] pad_word(input pad_buttons_t own, input pad_buttons_t extra,
                                           input logic [7:0] sig, input logic mt);
    if (mt) begin
      pad_word = {sig, extra, own};
    end else begin
      pad_word = {16'hffff, own};
    end
  endfunction

  function automatic logic [23:0] next_chain(input logic [23:0] chain, input logic clk_q,
                                             input logic clk_now, input logic latch,
                                             input logic [23:0] load_word);
    // a falling strobe beats a latch
    if (clk_q && !clk_now) begin
      next_chain = {1'b0, chain[23:1]};
    end else if (latch) begin
      next_chain = load_word;
    end else begin
      next_chain = chain;
    end
  endfunction

  function automatic logic core_reset_rule();
    core_reset_rule = !m_init || m_cnt != 8'd0 || loader_fail || hold_reset;
  endfunction

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input mem_addr_t got, input mem_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flags(input string what, input mapper_flags_t got,
                             input mapper_flags_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // registers update on the edge from the inputs held across it
  task automatic advance_model();
    logic        cr;
    logic [23:0] word1, word2;
    cr = core_reset_rule();
    word1 = pad_word(p1_buttons, p3_buttons, MULTITAP_SIG_P3, multitap_enabled);
    word2 = pad_word(p2_buttons, p4_buttons, MULTITAP_SIG_P4, multitap_enabled);
    if (cr) begin
      m_chain1 = 24'd0;
      m_chain2 = 24'd0;
      m_clkq = 2'b00;
    end else begin
      m_chain1 = next_chain(m_chain1, m_clkq[0], joypad_clock[0], joypad_latch, word1);
      m_chain2 = next_chain(m_chain2, m_clkq[1], joypad_clock[1], joypad_latch, word2);
      m_clkq = joypad_clock;
    end
    if (reset_nes) begin
      m_cnt = 8'd0;
      m_init = 1'b0;
      m_prev = 1'b0;
      m_lreset = 1'b1;
      m_flags = 64'd0;
    end else begin
      m_lreset = (m_cnt == 8'd0) | (ioctl_download & ~m_prev);
      if (ioctl_download) begin
        m_cnt = DL_RESET_CYCLES;
        m_init = 1'b1;
      end else if (!loader_busy && m_cnt != 8'd0) begin
        m_cnt = m_cnt - 8'd1;
      end
      m_prev = ioctl_download;
      if (loader_done) begin
        m_flags = loader_flags;
      end
    end
  endtask

  task automatic compare_outputs();
    logic active;
    active = ioctl_download | loader_busy;
    check_bit("core_reset", core_reset, core_reset_rule());
    check_bit("loader_reset", loader_reset, m_lreset);
    check_flags("core_mapper_flags", core_mapper_flags, ioctl_download ? 64'd0 : m_flags);
    check_bit("has_save", has_save, m_flags[HAS_SAVE_BIT]);
    check_byte("joypad1_data", {3'b000, joypad1_data}, {7'd0, m_chain1[0]});
    check_byte("joypad2_data", {3'b000, joypad2_data}, {7'd0, m_chain2[0]});
    check_addr("ch0_addr", ch0_addr, active ? loader_addr : {3'b000, ppu_addr});
    check_byte("ch0_din", ch0_din, active ? loader_write_data : ppu_dout);
    check_bit("ch0_wr", ch0_wr, loader_write | ppu_write);
    check_bit("ch0_rd", ch0_rd, !active && ppu_read);
    check_addr("ch2_addr", ch2_addr, {7'b0001111, sd_buff_addr});
    check_byte("ch2_din", ch2_din, sd_buff_dout);
    check_bit("ch2_wr", ch2_wr, sd_buff_wr && !save_busy);
    check_bit("ch2_rd", ch2_rd, sd_buff_rd && !save_busy);
    check_byte("sd_buff_din", sd_buff_din, bram_en ? eeprom_dout : save_dout);
  endtask

  // outputs are compared mid-cycle and new inputs go in 1 ns after the edge
  task automatic next_cycle();
    #4;
    if (model_ready) begin
      compare_outputs();
    end
    @(posedge clk_ppu_21_47);
    advance_model();
    #1;
  endtask

  task automatic drive_traffic();
    logic [31:0] r;
    r = rand_word();
    loader_addr = r[24:0];
    r = rand_word();
    ppu_addr = r[21:0];
    r = rand_word();
    sd_buff_addr = r[17:0];
    r = rand_word();
    loader_write_data = r[7:0];
    ppu_dout = r[15:8];
    sd_buff_dout = r[23:16];
    save_dout = r[31:24];
    r = rand_word();
    eeprom_dout = r[7:0];
    loader_write = r[8];
    ppu_write = r[9];
    ppu_read = r[10];
    sd_buff_wr = r[11];
    sd_buff_rd = r[12];
    save_busy = r[13];
    bram_en = r[14];
    r = rand_word();
    loader_flags[31:0] = r;
    r = rand_word();
    loader_flags[63:32] = r;
  endtask

  task automatic run_download(input int len);
    int            i;
    int            n;
    logic [31:0]   r;
    logic          busy_now;
    mapper_flags_t flags_at_done;
    ioctl_download = 1'b1;
    for (i = 0; i < len; i++) begin
      r = rand_word();
      loader_busy = r[0];
      drive_traffic();
      next_cycle();
      check_flags("core_mapper_flags while downloading", core_mapper_flags, 64'd0);
    end
    ioctl_download = 1'b0;
    flags_at_done = 64'd0;
    // the edge that saw the last download cycle loaded the counter
    n = 1;
    i = 0;
    do begin
      r = rand_word();
      busy_now = (i < 5) ? 1'b1 : (r[1:0] == 2'b00);
      loader_busy = busy_now;
      drive_traffic();
      loader_done = (i == 5);
      if (i == 5) begin
        flags_at_done = loader_flags;
      end
      next_cycle();
      if (!busy_now) begin
        n++;
      end
      i++;
    end while (core_reset && i < 2000);
    loader_done = 1'b0;
    loader_busy = 1'b0;
    if (core_reset) begin
      timeouts++;
      timed_out = 1'b1;
      $display("timeout: core_reset still high 2000 cycles after the download ended");
    end else begin
      if (n != 256) begin
        errors++;
        $display("Error: %0t ns: core_reset fell after %0d non-busy cycles, expected 256",
                 $time, n);
      end
      check_flags("latched mapper flags", core_mapper_flags, flags_at_done);
      check_bit("latched has_save", has_save, flags_at_done[HAS_SAVE_BIT]);
    end
  endtask

  task automatic read_pads(input logic mt);
    int          i;
    logic [31:0] r;
    logic [23:0] w1, w2;
    r = rand_word();
    p1_buttons = r[7:0];
    p2_buttons = r[15:8];
    p3_buttons = r[23:16];
    p4_buttons = r[31:24];
    multitap_enabled = mt;
    w1 = pad_word(p1_buttons, p3_buttons, 8'h08, mt);
    w2 = pad_word(p2_buttons, p4_buttons, 8'h04, mt);
    joypad_clock = 2'b00;
    joypad_latch = 1'b1;
    next_cycle();
    joypad_latch = 1'b0;
    for (i = 0; i < 26; i++) begin
      check_byte("port 1 serial bit", {3'b000, joypad1_data}, {7'd0, w1[0]});
      check_byte("port 2 serial bit", {3'b000, joypad2_data}, {7'd0, w2[0]});
      joypad_clock = 2'b11;
      next_cycle();
      // with multitap the first strobe lands on a latch, and the shift wins
      joypad_latch = mt && (i == 0);
      joypad_clock = 2'b00;
      next_cycle();
      joypad_latch = 1'b0;
      w1 = w1 >> 1;
      w2 = w2 >> 1;
    end
  endtask

  task automatic random_traffic(input int cycles);
    int          k;
    logic [31:0] r;
    for (k = 0; k < cycles; k++) begin
      r = rand_word();
      if (r[5:0] == 6'd0) begin
        ioctl_download = ~ioctl_download;
      end
      loader_busy = (r[7:6] == 2'b00);
      loader_done = (r[11:8] == 4'd0);
      loader_fail = (r[16:12] == 5'd0);
      hold_reset = (r[21:17] == 5'd0);
      joypad_latch = r[22] & r[23];
      joypad_clock = r[25:24];
      multitap_enabled = r[26];
      r = rand_word();
      p1_buttons = r[7:0];
      p2_buttons = r[15:8];
      p3_buttons = r[23:16];
      p4_buttons = r[31:24];
      drive_traffic();
      next_cycle();
    end
  endtask

  initial begin
    seed = 68353;
    errors = 0;
    timeouts = 0;
    checks = 0;
    model_ready = 1'b0;
    timed_out = 1'b0;
    m_cnt = 8'd0;
    m_init = 1'b0;
    m_prev = 1'b0;
    m_lreset = 1'b1;
    m_flags = 64'd0;
    m_chain1 = 24'd0;
    m_chain2 = 24'd0;
    m_clkq = 2'b00;
    reset_nes = 1'b1;
    ioctl_download = 1'b0;
    loader_busy = 1'b0;
    loader_done = 1'b0;
    loader_fail = 1'b0;
    hold_reset = 1'b0;
    multitap_enabled = 1'b0;
    joypad_latch = 1'b0;
    joypad_clock = 2'b00;
    p1_buttons = 8'h00;
    p2_buttons = 8'h00;
    p3_buttons = 8'h00;
    p4_buttons = 8'h00;
    drive_traffic();
    repeat (4) begin
      @(posedge clk_ppu_21_47);
      advance_model();
      #1;
    end
    reset_nes = 1'b0;
    model_ready = 1'b1;
    // machine idles in reset until the first download
    repeat (20) begin
      loader_busy = rand_word() == 32'd0;
      drive_traffic();
      next_cycle();
    end
    check_bit("core_reset before first download", core_reset, 1'b1);
    run_download(12);
    if (!timed_out) begin
      loader_fail = 1'b1;
      next_cycle();
      check_bit("core_reset with loader_fail", core_reset, 1'b1);
      loader_fail = 1'b0;
      hold_reset = 1'b1;
      next_cycle();
      check_bit("core_reset with hold_reset", core_reset, 1'b1);
      hold_reset = 1'b0;
      next_cycle();
      read_pads(1'b0);
      read_pads(1'b1);
      random_traffic(600);
      ioctl_download = 1'b0;
      loader_done = 1'b0;
      loader_fail = 1'b0;
      hold_reset = 1'b0;
      run_download(30);
      if (!timed_out) begin
        read_pads(1'b1);
      end
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
nes_glue_pkg.sv
load_if.sv
reset_sequencer.sv
cart_config.sv
joypad_ports.sv
sdram_port_router.sv
nes_glue_top.sv
tb_nes_glue.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
TOP       := tb_nes_glue
FILELIST  := filelist.f
OBJDIR    := obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
